//--- hw/avmm_if.sv
interface avmm_if
    import avmm_pkg::*;
();

    // Request side, one word per access
    mem_addr_t address;
    logic      read;
    logic      write;
    mem_data_t writedata;

    // Agent side, stall and read response
    // A request is taken on an edge where it is high and waitrequest is low
    logic      waitrequest;
    mem_data_t readdata;
    // Single-cycle pulse, responses come back in request order
    logic      readdatavalid;

    // The requester, which holds a request stable while waitrequest is high
    modport host (
        output address,
        output read,
        output write,
        output writedata,
        input  waitrequest,
        input  readdata,
        input  readdatavalid
    );

    // The responder, a bank or the agent face of the multiplexer
    modport agent (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output waitrequest,
        output readdata,
        output readdatavalid
    );

endinterface

//--- hw/avmm_pkg.sv
`include "mem_test_macros.svh"

package avmm_pkg;

    // ==============================
    // Memory bus field types
    // ==============================

    // Word address within a single bank
    typedef logic [`MT_ADDR_W-1:0] mem_addr_t;

    // One data word on the bus, always written with all bytes enabled
    typedef logic [`MT_DATA_W-1:0] mem_data_t;

    // Index of the bank that the shared bus is steered to
    typedef logic [$clog2(`MT_NUM_BANKS)-1:0] bank_sel_t;

endpackage

//--- hw/bank_model.sv
`include "mem_test_macros.svh"

module bank_model
    import avmm_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    avmm_if.agent mem
);

    localparam int DEPTH = 1 << `MT_ADDR_W;
    localparam int LAT   = `MT_RD_LATENCY;
    localparam int REF_W = $clog2(`MT_REFRESH_PERIOD);

    mem_data_t        store [DEPTH];
    logic [REF_W-1:0] ref_cnt;
    logic             refresh;
    logic             rd_take;
    logic             wr_take;
    // Stage LAT-1 of each pipe is the bank output
    logic [LAT-1:0]   rd_valid_pipe;
    mem_data_t        rd_data_pipe [LAT];

    // Free-running refresh timer, the bank stalls on its last count
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ref_cnt <= '0;
        end
        else if (ref_cnt == REF_W'(`MT_REFRESH_PERIOD - 1))
        begin
            ref_cnt <= '0;
        end
        else
        begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    assign refresh         = (ref_cnt == REF_W'(`MT_REFRESH_PERIOD - 1));
    assign mem.waitrequest = refresh;

    // One request per cycle outside the refresh slot
    assign rd_take = mem.read && !refresh;
    assign wr_take = mem.write && !refresh;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid_pipe <= '0;
        end
        else
        begin
            rd_valid_pipe[0] <= rd_take;
            for (int i = 1; i < LAT; i++)
            begin
                rd_valid_pipe[i] <= rd_valid_pipe[i-1];
            end
        end
    end

    // Array read is taken every cycle, the valid pipe marks the real ones
    always_ff @(posedge clk)
    begin
        if (wr_take)
        begin
            store[mem.address] <= mem.writedata;
        end
        rd_data_pipe[0] <= store[mem.address];
        for (int i = 1; i < LAT; i++)
        begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
    end

    assign mem.readdata      = rd_data_pipe[LAT-1];
    assign mem.readdatavalid = rd_valid_pipe[LAT-1];

endmodule

//--- hw/bank_mux.sv
`include "mem_test_macros.svh"

module bank_mux
    import avmm_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  bank_sel_t bank_sel,
    avmm_if.agent     host,
    avmm_if.host      banks [`MT_NUM_BANKS]
);

    // Per-bank response signals flattened into arrays for indexing by bank_sel
    logic      bank_wait  [`MT_NUM_BANKS];
    logic      bank_valid [`MT_NUM_BANKS];
    mem_data_t bank_rdata [`MT_NUM_BANKS];

    genvar b;
    generate
        for (b = 0; b < `MT_NUM_BANKS; b = b + 1)
        begin : g_bank
            // Address and data go to every bank, which keeps fan-out simple
            assign banks[b].address   = host.address;
            assign banks[b].writedata = host.writedata;

            // Only the selected bank sees a request
            assign banks[b].read  = host.read && (bank_sel == bank_sel_t'(b));
            assign banks[b].write = host.write && (bank_sel == bank_sel_t'(b));

            assign bank_wait[b]  = banks[b].waitrequest;
            assign bank_valid[b] = banks[b].readdatavalid;
            assign bank_rdata[b] = banks[b].readdata;
        end
    endgenerate

    // Stall passes straight through so acceptance stays in the same cycle
    assign host.waitrequest = bank_wait[bank_sel];

    // Read response takes one extra register stage on the way back
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            host.readdatavalid <= 1'b0;
        end
        else
        begin
            host.readdatavalid <= bank_valid[bank_sel];
        end
    end

    always_ff @(posedge clk)
    begin
        host.readdata <= bank_rdata[bank_sel];
    end

endmodule

//--- hw/csr_block.sv
module csr_block
    import avmm_pkg::*;
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      csr_wr,
    input  logic      csr_rd,
    input  csr_addr_t csr_addr,
    input  mem_data_t csr_wdata,
    output mem_data_t csr_rdata,
    output logic      csr_rvalid,
    output logic      start,
    output mt_cmd_e   cmd,
    output mem_addr_t base_addr,
    output mem_data_t seed,
    output mem_addr_t count,
    output bank_sel_t bank_sel,
    input  logic      busy,
    input  mem_data_t rdata,
    input  mem_addr_t err_count,
    input  mem_addr_t fail_addr
);

    // Engine is running or has a launch pending this cycle
    logic      engaged;
    mem_data_t rd_mux;

    // The start pulse precedes busy by one cycle, so it counts as busy here
    // This keeps a STATUS poll right after a command from reading idle
    assign engaged = busy || start;

    // ==============================
    // Register writes
    // ==============================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            start     <= 1'b0;
            cmd       <= CMD_WRITE;
            base_addr <= '0;
            seed      <= '0;
            count     <= '0;
            bank_sel  <= '0;
        end
        else
        begin
            // Launch one cycle after the command write, only from idle
            start <= csr_wr && (csr_addr == CSR_CMD) && !engaged;
            if (csr_wr)
            begin
                case (csr_addr)
                    CSR_CMD:
                    begin
                        if (!engaged)
                        begin
                            cmd <= mt_cmd_e'(csr_wdata[1:0]);
                        end
                    end
                    CSR_ADDR:  base_addr <= csr_wdata[$bits(mem_addr_t)-1:0];
                    CSR_DATA:  seed <= csr_wdata;
                    CSR_COUNT: count <= csr_wdata[$bits(mem_addr_t)-1:0];
                    CSR_BANK:
                    begin
                        // Switching banks mid-test would misroute read responses
                        if (!engaged)
                        begin
                            bank_sel <= csr_wdata[$bits(bank_sel_t)-1:0];
                        end
                    end
                    default:
                    begin
                        // Writes to status and result offsets have no effect
                    end
                endcase
            end
        end
    end

    // ==============================
    // Register reads
    // ==============================

    always_comb
    begin
        case (csr_addr)
            CSR_CMD:       rd_mux = mem_data_t'(cmd);
            CSR_ADDR:      rd_mux = mem_data_t'(base_addr);
            CSR_DATA:      rd_mux = seed;
            CSR_COUNT:     rd_mux = mem_data_t'(count);
            CSR_BANK:      rd_mux = mem_data_t'(bank_sel);
            CSR_STATUS:    rd_mux = mem_data_t'(engaged);
            CSR_RDATA:     rd_mux = rdata;
            CSR_ERR_COUNT: rd_mux = mem_data_t'(err_count);
            CSR_FAIL_ADDR: rd_mux = mem_data_t'(fail_addr);
            default:       rd_mux = '0;
        endcase
    end

    // Read data follows the request by exactly one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            csr_rvalid <= 1'b0;
        end
        else
        begin
            csr_rvalid <= csr_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_rd)
        begin
            csr_rdata <= rd_mux;
        end
    end

endmodule

//--- hw/csr_pkg.sv
package csr_pkg;

    // ==============================
    // Register map
    // ==============================

    // Host register offset, in words
    typedef logic [3:0] csr_addr_t;

    // Test setup registers, writable by the host
    localparam csr_addr_t CSR_CMD       = 4'd0;
    localparam csr_addr_t CSR_ADDR      = 4'd1;
    localparam csr_addr_t CSR_DATA      = 4'd2;
    localparam csr_addr_t CSR_COUNT     = 4'd3;
    localparam csr_addr_t CSR_BANK      = 4'd4;

    // Status and result registers, read only
    // Bit 0 of STATUS is the busy flag
    localparam csr_addr_t CSR_STATUS    = 4'd5;
    localparam csr_addr_t CSR_RDATA     = 4'd6;
    localparam csr_addr_t CSR_ERR_COUNT = 4'd7;
    localparam csr_addr_t CSR_FAIL_ADDR = 4'd8;

    // ==============================
    // Engine encodings
    // ==============================

    // Opcode written to CSR_CMD, low two bits of the write data
    typedef enum logic [1:0] {
        CMD_WRITE,
        CMD_READ,
        CMD_FILL,
        CMD_CHECK
    } mt_cmd_e;

    // Test engine sequencer states
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } mt_state_e;

endpackage

//--- hw/mem_test_engine.sv
module mem_test_engine
    import avmm_pkg::*;
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  mt_cmd_e   cmd,
    input  mem_addr_t base_addr,
    input  mem_data_t seed,
    input  mem_addr_t count,
    output logic      busy,
    output mem_data_t rdata,
    output mem_addr_t err_count,
    output mem_addr_t fail_addr,
    avmm_if.host      mem
);

    // Reads allowed in flight, enough to cover the 3-cycle read round trip
    localparam int MAX_RD_INFLIGHT = 4;
    localparam int INF_W = $clog2(MAX_RD_INFLIGHT + 1);

    mt_state_e  state;
    // Command settings captured at launch, the host may rewrite its copies
    mt_cmd_e    op;
    mem_addr_t  op_base;
    mem_data_t  op_seed;
    mem_addr_t  op_total;
    // Next word to request, and next word whose response is expected
    mem_addr_t  issue_idx;
    mem_addr_t  rsp_idx;
    logic [INF_W-1:0] rd_inflight;
    logic       is_write;
    logic       req_ok;
    logic       req_accept;
    logic       rd_accept;
    mem_data_t  rsp_expect;
    logic       rsp_miss;

    // ==============================
    // Request side
    // ==============================

    assign is_write = (op == CMD_WRITE) || (op == CMD_FILL);

    // Words remain and, for reads, there is room in the in-flight window
    // Once raised this stays high until accepted, since the window only drains
    assign req_ok = (state == ISSUE) && (issue_idx != op_total) &&
                    (is_write || (rd_inflight < INF_W'(MAX_RD_INFLIGHT)));

    // Word i lives at start + i and holds seed + i
    assign mem.address   = op_base + issue_idx;
    assign mem.writedata = op_seed + mem_data_t'(issue_idx);
    assign mem.write     = req_ok && is_write;
    assign mem.read      = req_ok && !is_write;

    assign req_accept = req_ok && !mem.waitrequest;
    assign rd_accept  = req_accept && !is_write;

    // ==============================
    // Response side
    // ==============================

    assign rsp_expect = op_seed + mem_data_t'(rsp_idx);
    assign rsp_miss   = mem.readdatavalid && (op == CMD_CHECK) &&
                        (mem.readdata != rsp_expect);

    assign busy = (state != IDLE);

    // Single commands run as a one-word pattern
    always_ff @(posedge clk)
    begin
        if (start && (state == IDLE))
        begin
            op       <= cmd;
            op_base  <= base_addr;
            op_seed  <= seed;
            op_total <= ((cmd == CMD_WRITE) || (cmd == CMD_READ)) ? mem_addr_t'(1) : count;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= IDLE;
            issue_idx   <= '0;
            rsp_idx     <= '0;
            rd_inflight <= '0;
            rdata       <= '0;
            err_count   <= '0;
            fail_addr   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state     <= ISSUE;
                        issue_idx <= '0;
                        rsp_idx   <= '0;
                        // Results of an earlier check stay until a new check
                        if (cmd == CMD_CHECK)
                        begin
                            err_count <= '0;
                            fail_addr <= '0;
                        end
                    end
                end
                ISSUE:
                begin
                    // Index moves only when the bank takes the request
                    if (req_accept)
                    begin
                        issue_idx <= issue_idx + 1'b1;
                    end
                    if (issue_idx == op_total)
                    begin
                        state <= DRAIN;
                    end
                end
                DRAIN:
                begin
                    // Writes are done once accepted; reads wait for their data
                    if (rd_inflight == '0)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase

            if (rd_accept && !mem.readdatavalid)
            begin
                rd_inflight <= rd_inflight + 1'b1;
            end
            else if (!rd_accept && mem.readdatavalid)
            begin
                rd_inflight <= rd_inflight - 1'b1;
            end

            if (mem.readdatavalid)
            begin
                rsp_idx <= rsp_idx + 1'b1;
            end
            if (mem.readdatavalid && (op == CMD_READ))
            begin
                rdata <= mem.readdata;
            end
            // Only the first miscompare sets the failing address
            if (rsp_miss)
            begin
                err_count <= err_count + 1'b1;
                if (err_count == '0)
                begin
                    fail_addr <= op_base + rsp_idx;
                end
            end
        end
    end

endmodule

//--- hw/mem_test_top.sv
`include "mem_test_macros.svh"

module mem_test_top
    import avmm_pkg::*;
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      csr_wr,
    input  logic      csr_rd,
    input  csr_addr_t csr_addr,
    input  mem_data_t csr_wdata,
    output mem_data_t csr_rdata,
    output logic      csr_rvalid
);

    // Command launch and settings from the register file
    logic      start;
    mt_cmd_e   cmd;
    mem_addr_t base_addr;
    mem_data_t seed;
    mem_addr_t count;
    bank_sel_t bank_sel;

    // Engine status and results back to the register file
    logic      busy;
    mem_data_t rdata;
    mem_addr_t err_count;
    mem_addr_t fail_addr;

    // Shared engine bus, then one bus per bank behind the multiplexer
    avmm_if eng_bus ();
    avmm_if bank_bus [`MT_NUM_BANKS] ();

    csr_block u_csr (
        .clk,
        .arst_n,
        .csr_wr,
        .csr_rd,
        .csr_addr,
        .csr_wdata,
        .csr_rdata,
        .csr_rvalid,
        .start,
        .cmd,
        .base_addr,
        .seed,
        .count,
        .bank_sel,
        .busy,
        .rdata,
        .err_count,
        .fail_addr
    );

    mem_test_engine u_engine (
        .clk,
        .arst_n,
        .start,
        .cmd,
        .base_addr,
        .seed,
        .count,
        .busy,
        .rdata,
        .err_count,
        .fail_addr,
        .mem (eng_bus)
    );

    bank_mux u_mux (
        .clk,
        .arst_n,
        .bank_sel,
        .host  (eng_bus),
        .banks (bank_bus)
    );

    genvar b;
    generate
        for (b = 0; b < `MT_NUM_BANKS; b = b + 1)
        begin : g_bank
            bank_model u_bank (
                .clk,
                .arst_n,
                .mem (bank_bus[b])
            );
        end
    endgenerate

endmodule

//--- include/mem_test_macros.svh
`ifndef MEM_TEST_MACROS_SVH
`define MEM_TEST_MACROS_SVH

// ==============================
// Memory geometry
// ==============================

// Number of banks behind the bank multiplexer
`define MT_NUM_BANKS 2

// Word address width inside one bank
`define MT_ADDR_W 10

// Width of one memory word
`define MT_DATA_W 32

// ==============================
// Bank model timing
// ==============================

// Cycles from an accepted read to readdatavalid at the bank
`define MT_RD_LATENCY 2

// One refresh stall cycle in every period of this many cycles
`define MT_REFRESH_PERIOD 8

`endif

//--- mem_test_top.f
+incdir+include
hw/avmm_pkg.sv
hw/csr_pkg.sv
hw/avmm_if.sv
hw/csr_block.sv
hw/mem_test_engine.sv
hw/bank_mux.sv
hw/bank_model.sv
hw/mem_test_top.sv
sim/tb_mem_test.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_test -f mem_test_top.f -o tb_mem_test

./obj_dir/tb_mem_test > sim.log
cat sim.log

if grep -q "^Finished with no errors$" sim.log
then
    exit 0
else
    exit 1
fi

//--- sim/tb_mem_test.sv
`include "mem_test_macros.svh"

module tb_mem_test
    import avmm_pkg::*;
    import csr_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    // The tests move about 460 words at roughly one cycle per word
    // Refresh stalls and STATUS polling add a few cycles per command on top
    localparam int MAX_CYCLES  = 20000;
    // Cycles allowed for one register read response
    localparam int RVALID_WAIT = 8;

    logic      clk;
    logic      arst_n;
    logic      csr_wr;
    logic      csr_rd;
    csr_addr_t csr_addr;
    mem_data_t csr_wdata;
    mem_data_t csr_rdata;
    logic      csr_rvalid;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [15:0] lfsr;

    mem_test_top u_dut (
        .clk,
        .arst_n,
        .csr_wr,
        .csr_rd,
        .csr_addr,
        .csr_wdata,
        .csr_rdata,
        .csr_rvalid
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Run limit for a hung engine that never drops busy
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ==============================
    // Random data
    // ==============================

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step for every bit taken
    // The first bit taken ends up in the MSB
    function automatic mem_data_t random_bits(input int nbits);
        mem_data_t value;
        value = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = {value[$bits(mem_data_t)-2:0], lfsr[0]};
        end
        return value;
    endfunction

    // ==============================
    // Host access and checking
    // ==============================

    task automatic check_value(input string name, input mem_data_t expected,
                               input mem_data_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Every host task starts and ends 1 time unit after a rising edge
    task automatic csr_write(input csr_addr_t addr, input mem_data_t data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #1;
        csr_wr = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output mem_data_t data);
        int waited;
        csr_rd   = 1'b1;
        csr_addr = addr;
        @(posedge clk);
        #1;
        csr_rd = 1'b0;
        waited = 1;
        while (!csr_rvalid && (waited < RVALID_WAIT))
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!csr_rvalid)
        begin
            errors++;
            $display("Register read at offset %0d never returned a response", addr);
        end
        else
        begin
            // The response belongs exactly one cycle after the request
            check_value("csr read latency", 32'd1, mem_data_t'(waited));
        end
        data = csr_rdata;
    endtask

    // STATUS reads busy right after the command write, so polling can start at once
    task automatic wait_idle();
        mem_data_t status;
        status = 32'd1;
        while (status[0])
        begin
            csr_read(CSR_STATUS, status);
        end
    endtask

    task automatic run_cmd(input mt_cmd_e op);
        csr_write(CSR_CMD, mem_data_t'(op));
        wait_idle();
    endtask

    task automatic set_test(input bank_sel_t bank, input mem_addr_t addr,
                            input mem_data_t data, input mem_addr_t count);
        csr_write(CSR_BANK, mem_data_t'(bank));
        csr_write(CSR_ADDR, mem_data_t'(addr));
        csr_write(CSR_DATA, data);
        csr_write(CSR_COUNT, mem_data_t'(count));
    endtask

    task automatic write_word(input bank_sel_t bank, input mem_addr_t addr,
                              input mem_data_t data);
        set_test(bank, addr, data, 10'd1);
        run_cmd(CMD_WRITE);
    endtask

    task automatic read_word(input bank_sel_t bank, input mem_addr_t addr,
                             output mem_data_t data);
        set_test(bank, addr, 32'd0, 10'd1);
        run_cmd(CMD_READ);
        csr_read(CSR_RDATA, data);
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic reset_values();
        mem_data_t got;
        csr_read(CSR_STATUS, got);
        check_value("reset STATUS", 32'd0, got);
        csr_read(CSR_ERR_COUNT, got);
        check_value("reset ERR_COUNT", 32'd0, got);
        csr_read(CSR_RDATA, got);
        check_value("reset RDATA", 32'd0, got);
    endtask

    task automatic single_write_read();
        mem_addr_t addr;
        mem_data_t data;
        mem_data_t got;
        for (int b = 0; b < `MT_NUM_BANKS; b++)
        begin
            addr = mem_addr_t'(random_bits($bits(mem_addr_t)));
            data = random_bits($bits(mem_data_t));
            write_word(bank_sel_t'(b), addr, data);
            read_word(bank_sel_t'(b), addr, got);
            check_value("single write and read", data, got);
        end
    endtask

    // Same address in both banks with different words
    task automatic bank_isolation();
        mem_addr_t addr;
        mem_data_t data0;
        mem_data_t got;
        addr  = mem_addr_t'(random_bits($bits(mem_addr_t)));
        data0 = random_bits($bits(mem_data_t));
        write_word(1'b0, addr, data0);
        write_word(1'b1, addr, ~data0);
        read_word(1'b0, addr, got);
        check_value("bank isolation bank 0", data0, got);
        read_word(1'b1, addr, got);
        check_value("bank isolation bank 1", ~data0, got);
    endtask

    // Start near the top so the word addresses wrap past zero
    task automatic fill_and_check();
        mem_addr_t start;
        mem_data_t seed;
        mem_data_t got;
        int        spots [3] = '{0, 31, 63};
        start = 10'h3e0;
        seed  = random_bits($bits(mem_data_t));
        set_test(1'b0, start, seed, 10'd64);
        run_cmd(CMD_FILL);
        run_cmd(CMD_CHECK);
        csr_read(CSR_ERR_COUNT, got);
        check_value("fill check ERR_COUNT", 32'd0, got);
        foreach (spots[i])
        begin
            read_word(1'b0, start + mem_addr_t'(spots[i]), got);
            check_value("fill spot read", seed + mem_data_t'(spots[i]), got);
        end
    endtask

    task automatic single_miscompare();
        mem_addr_t start;
        mem_addr_t bad_addr;
        mem_data_t seed;
        mem_data_t got;
        int        k;
        k     = 13;
        start = mem_addr_t'(random_bits($bits(mem_addr_t)));
        seed  = random_bits($bits(mem_data_t));
        // Word addresses wrap at the bank size
        bad_addr = start + mem_addr_t'(k);
        set_test(1'b1, start, seed, 10'd32);
        run_cmd(CMD_FILL);
        // Corrupt word k with a value that cannot match the pattern
        write_word(1'b1, bad_addr, ~(seed + mem_data_t'(k)));
        set_test(1'b1, start, seed, 10'd32);
        run_cmd(CMD_CHECK);
        csr_read(CSR_ERR_COUNT, got);
        check_value("miscompare ERR_COUNT", 32'd1, got);
        csr_read(CSR_FAIL_ADDR, got);
        check_value("miscompare FAIL_ADDR", mem_data_t'(bad_addr), got);
    endtask

    task automatic bank_lock_during_fill();
        mem_addr_t start;
        mem_data_t seed;
        mem_data_t got;
        start = 10'h100;
        seed  = random_bits($bits(mem_data_t));
        // Bank 0 gets an inverted seed so every word there differs from the pattern
        set_test(1'b0, start, ~seed, 10'd64);
        run_cmd(CMD_FILL);
        set_test(1'b1, start, seed, 10'd64);
        csr_write(CSR_CMD, mem_data_t'(CMD_FILL));
        csr_write(CSR_BANK, 32'd0);
        wait_idle();
        csr_read(CSR_BANK, got);
        check_value("bank lock BANK", 32'd1, got);
        run_cmd(CMD_CHECK);
        csr_read(CSR_ERR_COUNT, got);
        check_value("bank lock ERR_COUNT bank 1", 32'd0, got);
        csr_write(CSR_BANK, 32'd0);
        run_cmd(CMD_CHECK);
        csr_read(CSR_ERR_COUNT, got);
        check_value("bank lock ERR_COUNT bank 0", 32'd64, got);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        csr_wr      = 1'b0;
        csr_rd      = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        lfsr        = 16'd43257;

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_values();
        single_write_read();
        bank_isolation();
        fill_and_check();
        single_miscompare();
        bank_lock_during_fill();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
